/* Makefile */
VERILATOR ?= verilator
TOP ?= DivUnitTb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: compile
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "No status line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* source/CorePkg.sv */
`default_nettype none

package CorePkg;

    localparam int WordWidth = 32;
    localparam int SqNBits = 7;
    localparam int TagBits = 7;

    typedef logic [WordWidth-1:0] Word;
    typedef logic [SqNBits-1:0] SqN; // Age by signed difference, wraps
    typedef logic [TagBits-1:0] Tag; // Physical destination register

    typedef enum logic [1:0] {
        DIV_DIV,
        DIV_DIVU,
        DIV_REM,
        DIV_REMU
    } DivOp;

    typedef enum logic [1:0] {
        FLAGS_NONE,
        FLAGS_BRANCH,
        FLAGS_TRAP,
        FLAGS_EXCEPT
    } Flags;

    typedef struct packed {
        logic valid;
        Word srcA;
        Word srcB;
        DivOp opcode;
        SqN sqN;
        Tag tagDst;
    } ExUop;

    typedef struct packed {
        logic valid;
        Word result;
        SqN sqN;
        Tag tagDst;
        Flags flags;
        logic doNotCommit;
    } ResUop;

    typedef struct packed {
        logic taken;
        SqN sqN;
    } BranchProv;

endpackage

`default_nettype wire

/* source/DivCore.sv */
`timescale 1ns/1ps
`default_nettype none

module DivCore
    import CorePkg::*, DivPkg::*;
#(
    parameter int DataWidth = 32,
    parameter int SqNWidth = 7
) (
    input logic clk,
    input logic rst,
    input DivJob job,
    input BranchProv branch,
    output logic done,
    output DivFinal fin
);

    localparam int CntWidth = $clog2(DataWidth);

    CoreState state;
    DivJob held;
    logic [CntWidth-1:0] cnt;
    logic [2*DataWidth:0] rem;
    logic [2*DataWidth:0] remShift;
    logic [2*DataWidth:0] divShift;
    logic [DataWidth-1:0] quo;
    logic signed [SqNWidth-1:0] ageDiff;
    logic flush;

    assign remShift = {rem[2*DataWidth-1:0], 1'b0};
    assign divShift = {1'b0, held.divisor, {DataWidth{1'b0}}}; // Divisor aligned to top half
    assign ageDiff = branch.sqN - held.sqN;
    assign flush = (state == ITERATE) && branch.taken && (ageDiff < 0);
    assign done = flush || (state == FINISH);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (job.valid) state <= ITERATE;
                ITERATE: begin
                    if (flush)
                        state <= IDLE; // Dropped, no result
                    else if (cnt == '0)
                        state <= FINISH;
                end
                FINISH: state <= IDLE;
                default: state <= IDLE;
            endcase
        end

        if (state == IDLE && job.valid) begin
            held <= job;
            rem <= {{(DataWidth+1){1'b0}}, job.dividend};
            quo <= '0;
            cnt <= CntWidth'(DataWidth - 1);
        end else if (state == ITERATE) begin
            // Sign of the current remainder picks subtract or add
            rem <= rem[2*DataWidth] ? remShift + divShift : remShift - divShift;
            quo <= {quo[DataWidth-2:0], ~rem[2*DataWidth]};
            cnt <= cnt - 1'b1;
        end
    end

    assign fin.valid = (state == FINISH);
    assign fin.partRem = rem[2*DataWidth:DataWidth];
    assign fin.quotient = quo;
    assign fin.divisor = held.divisor;
    assign fin.invert = held.invert;
    assign fin.wantRem = held.wantRem;
    assign fin.divByZero = held.divByZero;
    assign fin.dividend = held.dividend;
    assign fin.sqN = held.sqN;
    assign fin.tagDst = held.tagDst;

endmodule

`default_nettype wire

/* source/DivIssue.sv */
`timescale 1ns/1ps
`default_nettype none

module DivIssue
    import CorePkg::*, DivPkg::*;
#(
    parameter int DataWidth = 32,
    parameter int SqNWidth = 7
) (
    input logic clk,
    input logic rst,
    input logic en,
    input ExUop inUop,
    input BranchProv branch,
    input logic done,
    output logic busy,
    output DivJob job
);

    logic signedOp;
    logic negA;
    logic negB;
    logic wantRem;
    logic divByZero;
    logic accept;
    logic [DataWidth-1:0] magA;
    logic [DataWidth-1:0] magB;
    logic signed [SqNWidth-1:0] ageDiff;

    assign signedOp = (inUop.opcode == DIV_DIV) || (inUop.opcode == DIV_REM);
    assign negA = signedOp && inUop.srcA[DataWidth-1];
    assign negB = signedOp && inUop.srcB[DataWidth-1];
    assign magA = negA ? -inUop.srcA : inUop.srcA;
    assign magB = negB ? -inUop.srcB : inUop.srcB;
    assign wantRem = (inUop.opcode == DIV_REM) || (inUop.opcode == DIV_REMU);
    assign divByZero = (inUop.srcB == '0);

    assign ageDiff = inUop.sqN - branch.sqN; // <= 0 means not younger than branch
    assign accept = en && inUop.valid && !busy && (!branch.taken || ageDiff <= 0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            job.valid <= 1'b0;
        end else begin
            job.valid <= accept;
            if (accept)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0; // Result left or job flushed
        end

        if (accept) begin
            job.dividend <= magA;
            job.divisor <= magB;
            job.wantRem <= wantRem;
            job.divByZero <= divByZero;
            // Remainder takes the dividend's sign
            job.invert <= wantRem ? negA : ((negA ^ negB) && !divByZero);
            job.sqN <= inUop.sqN;
            job.tagDst <= inUop.tagDst;
        end
    end

endmodule

`default_nettype wire

/* source/DivPkg.sv */
`default_nettype none

package DivPkg;

    import CorePkg::*;

    typedef logic [WordWidth:0] PartRem; // Top half of the partial remainder, sign included

    typedef struct packed {
        logic valid;
        Word dividend; // Magnitude
        Word divisor; // Magnitude
        logic invert;
        logic wantRem;
        logic divByZero;
        SqN sqN;
        Tag tagDst;
    } DivJob;

    typedef struct packed {
        logic valid;
        PartRem partRem;
        Word quotient; // Raw non-restoring digits
        Word divisor;
        logic invert;
        logic wantRem;
        logic divByZero;
        Word dividend;
        SqN sqN;
        Tag tagDst;
    } DivFinal;

    typedef enum logic [1:0] {
        IDLE,
        ITERATE,
        FINISH
    } CoreState;

endpackage

`default_nettype wire

/* source/DivResult.sv */
`timescale 1ns/1ps
`default_nettype none

module DivResult
    import CorePkg::*, DivPkg::*;
#(
    parameter int DataWidth = 32,
    parameter int SqNWidth = 7
) (
    input logic clk,
    input logic rst,
    input DivFinal fin,
    output ResUop outUop
);

    logic remNeg;
    logic [DataWidth-1:0] quoRestored;
    logic [DataWidth-1:0] remFixed;
    logic [DataWidth-1:0] quoSigned;
    logic [DataWidth-1:0] remSigned;
    logic [DataWidth-1:0] value;

    assign remNeg = fin.partRem[DataWidth];

    // Digits are +1/-1, so q - ~q gives the binary quotient
    assign quoRestored = (fin.quotient - ~fin.quotient) - {{(DataWidth-1){1'b0}}, remNeg};
    assign remFixed = remNeg ? fin.partRem[DataWidth-1:0] + fin.divisor
                             : fin.partRem[DataWidth-1:0];

    assign quoSigned = fin.divByZero ? '1 : (fin.invert ? -quoRestored : quoRestored);
    assign remSigned = fin.divByZero ? (fin.invert ? -fin.dividend : fin.dividend)
                                     : (fin.invert ? -remFixed : remFixed);
    assign value = fin.wantRem ? remSigned : quoSigned;

    always_ff @(posedge clk) begin
        if (!rst)
            outUop.valid <= 1'b0;
        else
            outUop.valid <= fin.valid; // Single-cycle pulse

        if (fin.valid) begin
            outUop.result <= value;
            outUop.sqN <= fin.sqN[SqNWidth-1:0];
            outUop.tagDst <= fin.tagDst;
            outUop.flags <= FLAGS_NONE;
            outUop.doNotCommit <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/DivUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module DivUnit
    import CorePkg::*, DivPkg::*;
#(
    parameter int DataWidth = 32,
    parameter int SqNWidth = 7
) (
    input logic clk,
    input logic rst,
    input logic en,
    input ExUop inUop,
    input BranchProv branch,
    output logic busy,
    output ResUop outUop
);

    DivJob job;
    DivFinal fin;
    logic done;

    DivIssue #(.DataWidth(DataWidth), .SqNWidth(SqNWidth)) issue (
        .clk(clk),
        .rst(rst),
        .en(en),
        .inUop(inUop),
        .branch(branch),
        .done(done),
        .busy(busy),
        .job(job)
    );

    DivCore #(.DataWidth(DataWidth), .SqNWidth(SqNWidth)) core (
        .clk(clk),
        .rst(rst),
        .job(job),
        .branch(branch),
        .done(done),
        .fin(fin)
    );

    DivResult #(.DataWidth(DataWidth), .SqNWidth(SqNWidth)) result (
        .clk(clk),
        .rst(rst),
        .fin(fin),
        .outUop(outUop)
    );

endmodule

`default_nettype wire

/* tb.f */
source/CorePkg.sv
source/DivPkg.sv
source/DivIssue.sv
source/DivCore.sv
source/DivResult.sv
source/DivUnit.sv
verif/DivUnit_sva.sv
verif/DivUnitTb.sv

/* verif/DivUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module DivUnitTb
    import CorePkg::*;
();

    localparam int Timeout = 60;
    localparam int Latency = 35; // Driving edge to result

    logic clk = 1'b0;
    logic rst;
    logic en;
    ExUop inUop;
    BranchProv branch;
    logic busy;
    ResUop outUop;
    int mismatches = 0;
    int failures = 0;
    logic [31:0] rngState = 32'h77b5_0363;

    DivUnit #(.DataWidth(32), .SqNWidth(7)) DUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic isYounger(input SqN a, input SqN b);
        logic signed [6:0] diff;
        diff = a - b; // Sign of the wrapped difference gives the age
        return diff > 7'sd0;
    endfunction

    function automatic Word refResult(input DivOp op, input Word a, input Word b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        if (b == '0)
            return (op == DIV_DIV || op == DIV_DIVU) ? '1 : a;
        if (op == DIV_DIVU)
            return a / b;
        if (op == DIV_REMU)
            return a % b;
        if (a == 32'h8000_0000 && b == '1) // Signed overflow
            return (op == DIV_DIV) ? a : '0;
        return (op == DIV_DIV) ? sa / sb : sa % sb;
    endfunction

    task automatic checkWord(input string name, input Word got, input Word exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkTag(input string name, input Tag got, input Tag exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkSqN(input string name, input SqN got, input SqN exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkFlags(input string name, input Flags got, input Flags exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic reportFailure(input string what);
        failures++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // Drives one micro-op and watches the whole window for results
    task automatic runCase(input ExUop u, input logic enable, input int brDelay, input SqN brSqN,
                           input int intrAt, input Word expVal);
        ExUop intr;
        ResUop got;
        int hits;
        int firstAt;
        logic busySeen;
        logic expAccept;
        logic expResult;
        intr = u; // Second micro-op sent while busy
        intr.srcB = u.srcB + 32'd1;
        intr.tagDst = u.tagDst + 7'd1;
        hits = 0;
        firstAt = -1;
        busySeen = 1'b0;
        got = '0;
        expAccept = enable && !(brDelay == 0 && isYounger(u.sqN, brSqN));
        expResult = expAccept && !(brDelay >= 2 && isYounger(u.sqN, brSqN));
        @(posedge clk);
        en <= enable;
        inUop <= u;
        branch.taken <= (brDelay == 0);
        branch.sqN <= brSqN;
        for (int c = 1; c <= Timeout; c++) begin
            @(posedge clk);
            en <= (c == intrAt);
            inUop <= (c == intrAt) ? intr : '0;
            branch.taken <= (c == brDelay);
            @(negedge clk);
            busySeen = busySeen | busy;
            if (outUop.valid) begin
                hits++;
                if (firstAt < 0) begin
                    firstAt = c;
                    got = outUop;
                end
            end
        end
        if (busySeen !== expAccept)
            reportFailure(expAccept ? "micro-op was not accepted" : "micro-op was wrongly accepted");
        if (hits != int'(expResult))
            reportFailure($sformatf("expected %0d result cycles, saw %0d", expResult, hits));
        if (busy)
            reportFailure("busy still high at the end of the window");
        if (expResult && hits > 0) begin
            if (firstAt != Latency)
                reportFailure($sformatf("result after %0d cycles, not %0d", firstAt, Latency));
            checkFlags("outUop.flags", got.flags, FLAGS_NONE);
            checkBit("outUop.doNotCommit", got.doNotCommit, 1'b0);
            checkWord("outUop.result", got.result, expVal);
            checkSqN("outUop.sqN", got.sqN, u.sqN);
            checkTag("outUop.tagDst", got.tagDst, u.tagDst);
        end
    endtask

    initial begin
        int fd;
        int op;
        int sq;
        int tag;
        int delay;
        int brSq;
        Word a;
        Word b;
        Word expVal;
        string line;
        ExUop u;
        logic enable;
        rst = 1'b0;
        en = 1'b0;
        inUop = '0;
        branch = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;

        fd = $fopen("verif/div_tests.txt", "r");
        if (fd == 0)
            reportFailure("cannot open verif/div_tests.txt");
        while (fd != 0 && $fgets(line, fd) > 0) begin
            if (line.len() < 8 || line[0] == "#")
                continue;
            if ($sscanf(line, "%d %h %h %d %d %d %d %h",
                        op, a, b, sq, tag, delay, brSq, expVal) != 8) begin
                reportFailure({"unreadable test line: ", line});
                continue;
            end
            u = '{valid: 1'b1, srcA: a, srcB: b, opcode: DivOp'(op),
                  sqN: SqN'(sq), tagDst: Tag'(tag)};
            runCase(u, 1'b1, delay, SqN'(brSq), -1, expVal);
        end
        if (fd != 0)
            $fclose(fd);

        // Every third one has en low and some get a second micro-op while busy
        for (int i = 0; i < 30; i++) begin
            rngState = xorshift(rngState);
            a = rngState;
            rngState = xorshift(rngState);
            b = rngState >> rngState[4:0];
            enable = (i % 3) != 2;
            u = '{valid: 1'b1, srcA: a, srcB: b, opcode: DivOp'(i % 4),
                  sqN: SqN'(i), tagDst: Tag'(i + 64)};
            runCase(u, enable, -1, '0, (enable && i % 5 == 1) ? 4 + i : -1,
                    refResult(u.opcode, a, b));
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/DivUnit_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module DivUnitSva
    import CorePkg::*;
(
    input logic clk,
    input logic rst,
    input logic busy,
    input ResUop outUop
);

    resetClear: assert property (@(posedge clk) $rose(rst) |-> !busy && !outUop.valid)
        else $error("busy or result valid set when leaving reset");

    singlePulse: assert property (@(posedge clk) disable iff (!rst)
        outUop.valid |=> !outUop.valid)
        else $error("result valid held for two cycles");

    // Result only ever follows a busy cycle
    busyBefore: assert property (@(posedge clk) disable iff (!rst)
        $rose(outUop.valid) |-> $past(busy))
        else $error("result without busy in the cycle before");

endmodule

bind DivUnit DivUnitSva sva (
    .clk(clk),
    .rst(rst),
    .busy(busy),
    .outUop(outUop)
);

`default_nettype wire

/* verif/div_tests.txt */
# op(0 DIV 1 DIVU 2 REM 3 REMU) srcA srcB sqN tag brDelay(-1 none) brSqN expected
# brDelay counts cycles after the micro-op is driven; expected is unused when no result is due
1 00000064 00000007 1 10 -1 0 0000000e
3 00000064 00000007 2 11 -1 0 00000002
0 ffffff9c 00000007 3 12 -1 0 fffffff2
2 ffffff9c 00000007 4 13 -1 0 fffffffe
0 00000064 fffffff9 5 14 -1 0 fffffff2
0 ffffff9c fffffff9 6 15 -1 0 0000000e
2 ffffff9c fffffff9 7 16 -1 0 fffffffe
1 ffffffff 00000003 8 17 -1 0 55555555
3 12345678 87654321 9 18 -1 0 12345678
0 12345678 00000000 10 19 -1 0 ffffffff
1 ffff0000 00000000 11 20 -1 0 ffffffff
2 ffffff9c 00000000 12 21 -1 0 ffffff9c
3 80000001 00000000 13 22 -1 0 80000001
0 80000000 ffffffff 14 23 -1 0 80000000
2 80000000 ffffffff 15 24 -1 0 00000000
1 80000000 ffffffff 16 25 -1 0 00000000
3 80000000 ffffffff 17 26 -1 0 80000000
0 ffffff9c 00000007 30 27 10 25 00000000
1 00000064 00000007 31 28 2 20 00000000
3 0000ffff 00000003 32 29 33 20 00000000
2 ffffff9c 00000007 33 30 10 40 fffffffe
1 00000064 00000007 50 31 0 45 00000000
1 00000064 00000007 50 32 0 55 0000000e
3 00000064 00000007 120 33 0 5 00000002
0 00000064 00000007 3 34 5 126 00000000
